/* Bender.yml */
package:
  name: icache

sources:
  - include_dirs:
      - common
    files:
      - common/icache_pkg.sv
      - common/refill_if.sv
      - icache/icache_arrays.sv
      - icache/icache_ctrl.sv
      - icache/icache_refill.sv
      - icache/icache_victim.sv
      - rtl/icache_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/icache_asserts.sv
      - sim/tb_icache.sv

/* common/icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Cache geometry
`define ICACHE_NUM_SETS      8
`define ICACHE_NUM_WAYS      4
`define ICACHE_BLOCK_WORDS   4
`define ICACHE_WORD_BITS     32

// Field widths of a fetch address
`define ICACHE_INDEX_BITS    $clog2(`ICACHE_NUM_SETS)
`define ICACHE_WAY_BITS      $clog2(`ICACHE_NUM_WAYS)
`define ICACHE_WORDSEL_BITS  $clog2(`ICACHE_BLOCK_WORDS)
`define ICACHE_BYTE_BITS     2
`define ICACHE_TAG_BITS      (32 - `ICACHE_INDEX_BITS - `ICACHE_WORDSEL_BITS - `ICACHE_BYTE_BITS)

`endif

/* common/icache_pkg.sv */
`include "icache_consts.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_BITS-1:0]     tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0]   index_t;
    typedef logic [`ICACHE_WAY_BITS-1:0]     way_t;
    typedef logic [`ICACHE_WORDSEL_BITS-1:0] word_sel_t;

    // One full cache line with word 0 in the low bits
    typedef logic [`ICACHE_BLOCK_WORDS-1:0][`ICACHE_WORD_BITS-1:0] line_t;

    // Fetch address split into its cache fields
    typedef struct packed {
        tag_t                         tag;
        index_t                       index;
        word_sel_t                    word_sel;
        logic [`ICACHE_BYTE_BITS-1:0] byte_off;
    } addr_fields_t;

endpackage

/* common/refill_if.sv */
`timescale 1ns/10ps
`include "icache_consts.svh"

interface refill_if import icache_pkg::*; ();

    logic                         start;      // One-cycle pulse while the engine idles
    addr_fields_t                 line_addr;  // Full miss address
    logic                         done;       // One-cycle pulse
    line_t                        line_data;
    logic [`ICACHE_WORD_BITS-1:0] crit_word;  // Word the core asked for

    modport ctrl (
        output start,
        output line_addr,
        input  done,
        input  line_data,
        input  crit_word
    );

    modport engine (
        input  start,
        input  line_addr,
        output done,
        output line_data,
        output crit_word
    );

endinterface

/* icache/icache_arrays.sv */
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_arrays import icache_pkg::*; (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  index_t                       lookup_index,
    input  tag_t                         lookup_tag,
    input  word_sel_t                    lookup_word_sel,
    output logic                         lookup_hit,
    output logic [`ICACHE_WORD_BITS-1:0] lookup_word,
    output logic [`ICACHE_NUM_WAYS-1:0]  set_valid,
    input  logic                         wr_en,
    input  index_t                       wr_index,
    input  way_t                         wr_way,
    input  tag_t                         wr_tag,
    input  line_t                        wr_line
);

    logic [`ICACHE_NUM_SETS-1:0][`ICACHE_NUM_WAYS-1:0] valid_q;
    tag_t  tag_mem  [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    line_t data_mem [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];

    logic [`ICACHE_NUM_WAYS-1:0] way_match;

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index][wr_way] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (wr_en) begin
            tag_mem[wr_index][wr_way]  <= wr_tag;
            data_mem[wr_index][wr_way] <= wr_line;
        end
    end

    // All ways of the set compared at once
    always_comb begin
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            way_match[w] = valid_q[lookup_index][w] &&
                           (tag_mem[lookup_index][w] == lookup_tag);
        end
    end

    always_comb begin
        lookup_word = '0;
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (way_match[w]) begin
                lookup_word = data_mem[lookup_index][w][lookup_word_sel];
            end
        end
    end

    assign lookup_hit = |way_match;
    assign set_valid  = valid_q[lookup_index];

endmodule

/* icache/icache_ctrl.sv */
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  logic                         read_enable,
    input  logic [31:0]                  read_address,
    output logic [`ICACHE_WORD_BITS-1:0] instruction,
    output logic                         ready,
    output logic                         busy,
    refill_if.ctrl                       refill,
    output index_t                       lookup_index,
    input  logic                         lookup_hit,
    input  logic [`ICACHE_WORD_BITS-1:0] lookup_word,
    input  logic [`ICACHE_NUM_WAYS-1:0]  set_valid,
    output logic                         wr_en,
    output index_t                       wr_index,
    output way_t                         wr_way,
    output tag_t                         wr_tag,
    output line_t                        wr_line,
    input  way_t                         victim_way
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL
    } state_t;

    state_t                       state_q;
    addr_fields_t                 fetch_fields;
    addr_fields_t                 req_q;
    logic                         hit_q;
    logic [`ICACHE_WORD_BITS-1:0] hit_word_q;
    way_t                         way_q;
    logic                         set_full_q;
    logic                         start_q;
    logic                         accept;

    assign fetch_fields = read_address;
    assign accept       = read_enable && !busy && (state_q == S_IDLE);

    // Once accepted, the array keeps looking at the missed set
    assign lookup_index = (state_q == S_IDLE) ? fetch_fields.index : req_q.index;

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state_q     <= S_IDLE;
            ready       <= 1'b0;
            busy        <= 1'b0;
            start_q     <= 1'b0;
            instruction <= '0;
        end else begin
            ready   <= 1'b0;
            start_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (accept) state_q <= S_LOOKUP;
                end
                S_LOOKUP: begin
                    if (hit_q) begin
                        ready       <= 1'b1;
                        instruction <= hit_word_q;
                        state_q     <= S_IDLE;
                    end else begin
                        busy    <= 1'b1;
                        start_q <= 1'b1;
                        state_q <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (refill.done) begin
                        ready       <= 1'b1;
                        busy        <= 1'b0;
                        instruction <= refill.crit_word;
                        state_q     <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            req_q      <= fetch_fields;
            hit_q      <= lookup_hit;
            hit_word_q <= lookup_word;
        end
        if (state_q == S_LOOKUP) begin
            way_q      <= victim_way;
            set_full_q <= &set_valid;
        end
    end

    assign refill.start     = start_q;
    assign refill.line_addr = req_q;

    // A full set takes the random way at install time
    assign wr_en    = (state_q == S_FILL) && refill.done;
    assign wr_index = req_q.index;
    assign wr_tag   = req_q.tag;
    assign wr_way   = set_full_q ? victim_way : way_q;
    assign wr_line  = refill.line_data;

endmodule

/* icache/icache_refill.sv */
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_refill import icache_pkg::*; (
    input  logic                         Clk,
    input  logic                         rst_n,
    refill_if.engine                     refill,
    output logic [31:0]                  mem_read_address,
    output logic                         mem_read_request,
    input  logic [`ICACHE_WORD_BITS-1:0] mem_data_in,
    input  logic                         mem_data_ready
);

    localparam word_sel_t LAST_WORD = word_sel_t'(`ICACHE_BLOCK_WORDS - 1);

    addr_fields_t req_q;
    addr_fields_t line_base;
    word_sel_t    cnt_q;
    line_t        buf_q;
    logic         done_q;
    logic         take_word;

    assign take_word = mem_read_request && mem_data_ready;

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            mem_read_request <= 1'b0;
            cnt_q            <= '0;
            done_q           <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (refill.start) begin
                mem_read_request <= 1'b1;
                cnt_q            <= '0;
            end else if (take_word) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == LAST_WORD) begin
                    mem_read_request <= 1'b0;  // Drops with the last word
                    done_q           <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (refill.start) req_q <= refill.line_addr;
        if (take_word) buf_q[cnt_q] <= mem_data_in;
    end

    // Line aligned request
    always_comb begin
        line_base          = req_q;
        line_base.word_sel = '0;
        line_base.byte_off = '0;
    end

    assign mem_read_address = line_base;
    assign refill.done      = done_q;
    assign refill.line_data = buf_q;
    assign refill.crit_word = buf_q[req_q.word_sel];

endmodule

/* icache/icache_victim.sv */
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_victim import icache_pkg::*; (
    input  logic                        Clk,
    input  logic                        rst_n,
    input  logic [`ICACHE_NUM_WAYS-1:0] set_valid,
    output way_t                        victim_way
);

    logic [15:0] lfsr_q;
    logic        feedback;

    // Taps 16, 14, 13, 11
    assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            lfsr_q <= 16'hace1;  // Any nonzero seed
        end else begin
            lfsr_q <= {lfsr_q[14:0], feedback};
        end
    end

    // Lowest invalid way wins over the LFSR
    always_comb begin
        victim_way = lfsr_q[`ICACHE_WAY_BITS-1:0];
        for (int w = `ICACHE_NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) victim_way = way_t'(w);
        end
    end

endmodule

/* project.f */
+incdir+common
common/icache_pkg.sv
common/refill_if.sv
icache/icache_arrays.sv
icache/icache_ctrl.sv
icache/icache_refill.sv
icache/icache_victim.sv
rtl/icache_top.sv
sim/icache_asserts.sv
sim/tb_icache.sv

/* rtl/icache_top.sv */
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  logic                         read_enable,
    input  logic [31:0]                  read_address,
    output logic [`ICACHE_WORD_BITS-1:0] instruction,
    output logic                         ready,
    output logic                         busy,
    output logic [31:0]                  mem_read_address,
    output logic                         mem_read_request,
    input  logic [`ICACHE_WORD_BITS-1:0] mem_data_in,
    input  logic                         mem_data_ready
);

    refill_if rif ();

    addr_fields_t                 fetch_fields;
    index_t                       lookup_index;
    logic                         lookup_hit;
    logic [`ICACHE_WORD_BITS-1:0] lookup_word;
    logic [`ICACHE_NUM_WAYS-1:0]  set_valid;
    logic                         wr_en;
    index_t                       wr_index;
    way_t                         wr_way;
    tag_t                         wr_tag;
    line_t                        wr_line;
    way_t                         victim_way;

    assign fetch_fields = read_address;

    icache_ctrl u_ctrl (
        .Clk, .rst_n, .read_enable, .read_address, .instruction, .ready, .busy,
        .refill(rif.ctrl), .lookup_index, .lookup_hit, .lookup_word, .set_valid,
        .wr_en, .wr_index, .wr_way, .wr_tag, .wr_line, .victim_way
    );

    icache_arrays u_arrays (
        .Clk, .rst_n, .lookup_index,
        .lookup_tag(fetch_fields.tag), .lookup_word_sel(fetch_fields.word_sel),
        .lookup_hit, .lookup_word, .set_valid,
        .wr_en, .wr_index, .wr_way, .wr_tag, .wr_line
    );

    icache_refill u_refill (
        .Clk, .rst_n, .refill(rif.engine),
        .mem_read_address, .mem_read_request, .mem_data_in, .mem_data_ready
    );

    icache_victim u_victim (.Clk, .rst_n, .set_valid, .victim_way);

endmodule

/* sim/icache_asserts.sv */
`timescale 1ns/10ps

module icache_asserts (
    input logic        Clk,
    input logic        rst_n,
    input logic        ready,
    input logic        busy,
    input logic        mem_read_request,
    input logic [31:0] mem_read_address
);

    int assert_errors = 0;

    assert property (@(posedge Clk) disable iff (!rst_n) mem_read_request |-> busy)
        else begin
            $error("memory request outside a busy refill");
            assert_errors++;
        end

    assert property (@(posedge Clk) disable iff (!rst_n) ready |=> !ready)
        else begin
            $error("ready high two cycles in a row");
            assert_errors++;
        end

    assert property (@(posedge Clk) disable iff (!rst_n)
                     mem_read_request |-> (mem_read_address[3:0] == 4'h0))
        else begin
            $error("memory request address not line aligned");
            assert_errors++;
        end

    // Held until the last strobe
    assert property (@(posedge Clk) disable iff (!rst_n)
                     mem_read_request |=> (!mem_read_request || $stable(mem_read_address)))
        else begin
            $error("memory request address changed during a refill");
            assert_errors++;
        end

endmodule

bind icache_top icache_asserts u_asserts (
    .Clk, .rst_n, .ready, .busy, .mem_read_request, .mem_read_address
);

/* sim/tb_icache.sv */
`timescale 1ns/10ps
`include "icache_consts.svh"

module tb_icache;

    localparam int LINE_BYTES    = 4 * `ICACHE_BLOCK_WORDS;
    localparam int SET_STRIDE    = LINE_BYTES * `ICACHE_NUM_SETS;  // Same set with the next tag
    localparam int MAX_GAP       = 3;
    localparam int REFILL_CYCLES = `ICACHE_BLOCK_WORDS * (MAX_GAP + 1) + 4;
    localparam int RAND_FETCHES  = 40;
    localparam int NUM_FETCHES   = 2 + 8 + 6 + RAND_FETCHES;
    localparam int TIMEOUT       = 40 * NUM_FETCHES * REFILL_CYCLES;

    logic        Clk = 1'b0;
    logic        rst_n;
    logic        read_enable;
    logic        ready;
    logic        busy;
    logic        mem_read_request;
    logic        mem_data_ready;
    logic [31:0] read_address;
    logic [31:0] instruction;
    logic [31:0] mem_read_address;
    logic [31:0] mem_data_in;
    logic [31:0] gap_seed  = 32'd67823;
    logic [31:0] stim_seed = 32'd67823;
    logic [31:0] last_req_addr;
    logic [31:0] expected_q[$];  // Accepted fetch addresses
    int          mem_reqs = 0;
    int          checks   = 0;
    int          errors   = 0;
    int          cycles   = 0;

    icache_top DUT (.*);

    always #10 Clk = ~Clk;

    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        return state >> 8;
    endfunction

    // Memory image hashed from the word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] w;
        w = addr >> 2;
        return (w * 32'h9e3779b1) ^ {w[12:0], w[31:13]} ^ 32'h5a5a_c3c3;
    endfunction

    task automatic next_cycle();
        @(posedge Clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors == errs_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
    endtask

    // Latency counts cycles from the accepting edge to ready
    task automatic fetch(input logic [31:0] addr, input bit noisy, output int latency);
        logic [31:0] r;
        read_enable  = 1'b1;
        read_address = addr;
        next_cycle();
        expected_q.push_back(addr);
        read_enable = 1'b0;
        latency = 0;
        do begin
            next_cycle();
            latency++;
            r = lcg_next(stim_seed);
            read_enable = noisy && busy && r[4];  // Ignored by the DUT
            if (read_enable) read_address = 32'h3000 + {r[15:8], 2'b00};
        end while (!ready);
    endtask

    // SDRAM model
    task automatic serve_line(input logic [31:0] base);
        int gap;
        mem_reqs++;
        last_req_addr = base;
        for (int k = 0; k < `ICACHE_BLOCK_WORDS; k++) begin
            gap = int'(lcg_next(gap_seed) % (MAX_GAP + 1));
            repeat (gap) next_cycle();
            mem_data_ready = 1'b1;
            mem_data_in    = mem_word(base + 4 * k);
            next_cycle();
            mem_data_ready = 1'b0;
        end
    endtask

    initial begin
        mem_data_ready = 1'b0;
        mem_data_in    = '0;
        forever begin
            next_cycle();
            if (mem_read_request) serve_line(mem_read_address);
        end
    end

    always @(posedge Clk) begin
        #2;
        if (ready && expected_q.size() == 0) begin
            $display("ready pulsed with no accepted fetch outstanding");
            errors++;
        end else if (ready) begin
            check_value("instruction", instruction, mem_word(expected_q.pop_front()));
        end
    end

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge Clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int          lat;
        int          errs;
        int          reqs;
        int          misses;
        logic [31:0] base;
        rst_n        = 1'b0;
        read_enable  = 1'b0;
        read_address = '0;
        repeat (8) @(posedge Clk);
        #2;
        rst_n = 1'b1;

        errs = errors;
        repeat (5) begin
            next_cycle();
            check_value("ready", ready, 0);
            check_value("busy", busy, 0);
            check_value("mem_read_request", mem_read_request, 0);
        end
        check_value("instruction", instruction, 0);
        report_test(1, "idle after reset", errs);

        errs = errors;
        reqs = mem_reqs;
        fetch(32'h0000_0104, 1'b0, lat);
        check_value("memory requests", mem_reqs - reqs, 1);
        check_value("mem_read_address", last_req_addr, 32'h0000_0100);
        report_test(2, "cold miss", errs);

        errs = errors;
        reqs = mem_reqs;
        fetch(32'h0000_010c, 1'b0, lat);
        check_value("ready latency", lat, 1);
        check_value("memory requests", mem_reqs - reqs, 0);
        report_test(3, "hit in the same line", errs);

        errs = errors;
        base = 32'h0000_2030;  // Set 3
        reqs = mem_reqs;
        for (int t = 0; t < 4; t++) fetch(base + t * SET_STRIDE, 1'b0, lat);
        check_value("memory requests", mem_reqs - reqs, 4);
        reqs = mem_reqs;
        for (int t = 0; t < 4; t++) begin
            fetch(base + t * SET_STRIDE + 8, 1'b0, lat);
            check_value("ready latency", lat, 1);
        end
        check_value("memory requests", mem_reqs - reqs, 0);
        report_test(4, "four lines in one set", errs);

        errs = errors;
        reqs = mem_reqs;
        fetch(base + 4 * SET_STRIDE, 1'b0, lat);
        fetch(base + 4 * SET_STRIDE + 4, 1'b0, lat);
        check_value("ready latency", lat, 1);
        check_value("memory requests", mem_reqs - reqs, 1);
        reqs   = mem_reqs;
        misses = 0;
        for (int t = 0; t < 4; t++) begin
            fetch(base + t * SET_STRIDE + 12, 1'b0, lat);
            if (lat > 1) misses++;
        end
        checks++;
        if (misses == 0) begin
            $display("the fifth line evicted none of the four earlier lines");
            errors++;
        end
        check_value("memory requests", mem_reqs - reqs, misses);
        report_test(5, "eviction", errs);

        errs = errors;
        for (int i = 0; i < RAND_FETCHES; i++) begin
            base = lcg_next(stim_seed);
            fetch(32'h3000 + {base[15:8], 2'b00}, 1'b1, lat);
        end
        repeat (4) next_cycle();
        check_value("outstanding fetches", expected_q.size(), 0);
        report_test(6, "random fetches", errs);

        errors += DUT.u_asserts.assert_errors;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, DUT.u_asserts.assert_errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
